// File: Makefile
TOP = cam_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f cam.f --top-module $(TOP)

sim:
	verilator --binary --timing --timescale 1ns/1ps -f cam.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

// File: cam.f
+incdir+logic
logic/cam_pkg.sv
logic/cam_free_list.sv
logic/cam_alloc.sv
logic/cam_array.sv
logic/cam_search.sv
logic/cam_top.sv
tests/cam_checker.sv
tests/cam_tb.sv

// File: logic/cam_alloc.sv
`timescale 1ns/1ps
`include "cam_defines.svh"

module cam_alloc
  import cam_pkg::*;
(
  input  logic     clk,
  input  logic     rst_an,
  input  logic     write_valid,
  output logic     wr_en,
  output cam_loc_t wr_loc,
  input  logic     free_en,
  input  cam_loc_t free_loc,
  output logic     wcredit
);

  cam_loc_t fresh_cnt;
  logic     exhausted;
  logic     pop;
  cam_loc_t pop_loc;
  logic     not_empty;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // fresh locations.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // hands out 0 .. depth-1 once, then stays exhausted.
  always_ff @(posedge clk or negedge rst_an) begin
    if (!rst_an) begin
      fresh_cnt <= '0;
      exhausted <= 1'b0;
    end else if (write_valid && !exhausted) begin
      if (fresh_cnt == cam_loc_t'(`CAM_DEPTH - 1)) begin
        exhausted <= 1'b1;
      end else begin
        fresh_cnt <= fresh_cnt + 1'b1;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // recycled locations.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign pop = write_valid && exhausted && not_empty;

  cam_free_list cam_free_list_inst (
    .clk       (clk),
    .rst_an    (rst_an),
    .push      (free_en),
    .push_loc  (free_loc),
    .pop       (pop),
    .pop_loc   (pop_loc),
    .not_empty (not_empty)
  );

  // a write with no location to go to is dropped.
  assign wr_en  = write_valid && (!exhausted || not_empty);
  assign wr_loc = exhausted ? pop_loc : fresh_cnt;

  // one credit back per freed location.
  always_ff @(posedge clk or negedge rst_an) begin
    if (!rst_an) begin
      wcredit <= 1'b0;
    end else begin
      wcredit <= free_en;
    end
  end

endmodule

// File: logic/cam_array.sv
`timescale 1ns/1ps
`include "cam_defines.svh"

module cam_array
  import cam_pkg::*;
(
  input  logic         clk,
  input  logic         rst_an,
  input  logic         wr_en,
  input  cam_loc_t     wr_loc,
  input  cam_data_t    wr_data,
  input  logic         free_en,
  input  cam_loc_t     free_loc,
  output cam_entries_t entries,
  output cam_valid_t   valid
);

  cam_data_t mem [`CAM_DEPTH];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // entry data.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_loc] <= wr_data;
    end
  end

  // flatten for the compare logic.
  always_comb begin
    for (int i = 0; i < `CAM_DEPTH; i++) begin
      entries[i*`CAM_DATA_W +: `CAM_DATA_W] = mem[i];
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // valid bits.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // a location is never written and freed at the same edge.
  always_ff @(posedge clk or negedge rst_an) begin
    if (!rst_an) begin
      valid <= '0;
    end else begin
      if (free_en) begin
        valid[free_loc] <= 1'b0;
      end
      if (wr_en) begin
        valid[wr_loc] <= 1'b1;
      end
    end
  end

endmodule

// File: logic/cam_defines.svh
`ifndef CAM_DEFINES_SVH
`define CAM_DEFINES_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cam geometry.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// number of entries, also the depth of the free list.
`define CAM_DEPTH 100

// width of one stored entry.
`define CAM_DATA_W 20

// search key, taken from the low bits of an entry.
`define CAM_KEY_W 15

// enough bits to index every location.
`define CAM_LOC_W 7

`endif

// File: logic/cam_free_list.sv
`timescale 1ns/1ps
`include "cam_defines.svh"

module cam_free_list
  import cam_pkg::*;
(
  input  logic     clk,
  input  logic     rst_an,
  input  logic     push,
  input  cam_loc_t push_loc,
  input  logic     pop,
  output cam_loc_t pop_loc,
  output logic     not_empty
);

  cam_loc_t             mem [`CAM_DEPTH];
  cam_loc_t             wr_ptr;
  cam_loc_t             rd_ptr;
  logic [`CAM_LOC_W:0]  fill_cnt;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // storage.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_loc;
    end
  end

  assign pop_loc   = mem[rd_ptr];
  assign not_empty = (fill_cnt != '0);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // pointers and fill level.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // pointers wrap at depth, which is not a power of two.
  always_ff @(posedge clk or negedge rst_an) begin
    if (!rst_an) begin
      wr_ptr <= '0;
    end else if (push) begin
      if (wr_ptr == cam_loc_t'(`CAM_DEPTH - 1)) begin
        wr_ptr <= '0;
      end else begin
        wr_ptr <= wr_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_an) begin
    if (!rst_an) begin
      rd_ptr <= '0;
    end else if (pop) begin
      if (rd_ptr == cam_loc_t'(`CAM_DEPTH - 1)) begin
        rd_ptr <= '0;
      end else begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_an) begin
    if (!rst_an) begin
      fill_cnt <= '0;
    end else begin
      case ({push, pop})
        2'b10:   fill_cnt <= fill_cnt + 1'b1;
        2'b01:   fill_cnt <= fill_cnt - 1'b1;
        default: fill_cnt <= fill_cnt;
      endcase
    end
  end

endmodule

// File: logic/cam_pkg.sv
`include "cam_defines.svh"

package cam_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // shared vector types.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // one stored entry.
  typedef logic [`CAM_DATA_W-1:0] cam_data_t;

  // search key, the low bits of an entry.
  typedef logic [`CAM_KEY_W-1:0] cam_key_t;

  // location index into the entry array.
  typedef logic [`CAM_LOC_W-1:0] cam_loc_t;

  // one valid bit per location.
  typedef logic [`CAM_DEPTH-1:0] cam_valid_t;

  // all entries side by side, location 0 in the low bits.
  typedef logic [`CAM_DEPTH*`CAM_DATA_W-1:0] cam_entries_t;

endpackage

// File: logic/cam_search.sv
`timescale 1ns/1ps
`include "cam_defines.svh"

module cam_search
  import cam_pkg::*;
(
  input  logic         clk,
  input  logic         rst_an,
  input  logic         search_valid,
  input  cam_key_t     search_key,
  input  cam_entries_t entries,
  input  cam_valid_t   valid,
  output logic         hit_valid,
  output logic         hit,
  output cam_data_t    hit_data,
  output logic         free_en,
  output cam_loc_t     free_loc
);

  cam_valid_t pend_mask;
  cam_valid_t live;
  cam_valid_t match;
  logic       found;
  cam_loc_t   sel_loc;
  cam_data_t  sel_data;
  logic       hit_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // compare.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // the entry hit last cycle is still valid in the array
  // until the free lands, so hide it from this search.
  assign pend_mask = free_en ? (cam_valid_t'(1) << free_loc) : '0;
  assign live      = valid & ~pend_mask;

  always_comb begin
    for (int i = 0; i < `CAM_DEPTH; i++) begin
      match[i] = live[i] &&
                 (entries[i*`CAM_DATA_W +: `CAM_KEY_W] == search_key);
    end
  end

  // lowest index wins; scan downward so it is applied last.
  always_comb begin
    found    = 1'b0;
    sel_loc  = '0;
    sel_data = '0;
    for (int i = `CAM_DEPTH - 1; i >= 0; i--) begin
      if (match[i]) begin
        found    = 1'b1;
        sel_loc  = cam_loc_t'(i);
        sel_data = entries[i*`CAM_DATA_W +: `CAM_DATA_W];
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // result registers.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or negedge rst_an) begin
    if (!rst_an) begin
      hit_valid <= 1'b0;
      hit_q     <= 1'b0;
    end else begin
      hit_valid <= search_valid;
      hit_q     <= search_valid && found;
    end
  end

  always_ff @(posedge clk) begin
    if (search_valid) begin
      hit_data <= sel_data;
      free_loc <= sel_loc;
    end
  end

  // every hit frees the entry it returned.
  assign hit     = hit_q;
  assign free_en = hit_q;

endmodule

// File: logic/cam_top.sv
`timescale 1ns/1ps

module cam_top
  import cam_pkg::*;
(
  input  logic      clk,
  input  logic      rst_an,

  // write side, credit based.
  input  logic      write_valid,
  input  cam_data_t write_data,
  output logic      wcredit,

  // search side.
  input  logic      search_valid,
  input  cam_key_t  search_key,

  // search result, one cycle after the search.
  output logic      hit_valid,
  output logic      hit,
  output cam_data_t hit_data
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // internal connections.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  logic         wr_en;
  cam_loc_t     wr_loc;
  logic         free_en;
  cam_loc_t     free_loc;
  cam_entries_t entries;
  cam_valid_t   valid;

  // location allocation and credit return.
  cam_alloc cam_alloc_inst (
    .clk         (clk),
    .rst_an      (rst_an),
    .write_valid (write_valid),
    .wr_en       (wr_en),
    .wr_loc      (wr_loc),
    .free_en     (free_en),
    .free_loc    (free_loc),
    .wcredit     (wcredit)
  );

  // entry storage.
  cam_array cam_array_inst (
    .clk      (clk),
    .rst_an   (rst_an),
    .wr_en    (wr_en),
    .wr_loc   (wr_loc),
    .wr_data  (write_data),
    .free_en  (free_en),
    .free_loc (free_loc),
    .entries  (entries),
    .valid    (valid)
  );

  // key compare and hit select.
  // the free request also feeds the allocator.
  cam_search cam_search_inst (
    .clk          (clk),
    .rst_an       (rst_an),
    .search_valid (search_valid),
    .search_key   (search_key),
    .entries      (entries),
    .valid        (valid),
    .hit_valid    (hit_valid),
    .hit          (hit),
    .hit_data     (hit_data),
    .free_en      (free_en),
    .free_loc     (free_loc)
  );

endmodule

// File: tests/cam_checker.sv
`timescale 1ns/1ps

module cam_checker
  import cam_pkg::*;
(
  input  logic      clk,
  input  logic      rst_an,
  input  logic      search_valid,
  input  cam_key_t  search_key,
  input  logic      exp_hit,
  input  cam_data_t exp_data,
  input  logic      hit_valid,
  input  logic      hit,
  input  cam_data_t hit_data,
  input  logic      wcredit,
  output int        errors,
  output int        pulses
);

  logic      pend_valid;
  logic      pend_hit;
  logic      credit_due;
  cam_key_t  pend_key;
  cam_data_t pend_data;
  int        err_cnt = 0;
  int        pulse_cnt = 0;

  assign errors = err_cnt;
  assign pulses = pulse_cnt;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // expectations lined up with the dut pipeline.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // result one cycle after the search, credit one cycle later.
  always_ff @(posedge clk or negedge rst_an) begin
    if (!rst_an) begin
      pend_valid <= 1'b0;
      pend_hit   <= 1'b0;
      credit_due <= 1'b0;
    end else begin
      pend_valid <= search_valid;
      pend_hit   <= search_valid && exp_hit;
      credit_due <= pend_hit;
    end
  end

  always_ff @(posedge clk) begin
    pend_key  <= search_key;
    pend_data <= exp_data;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // compare on the falling edge.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(negedge clk) begin
    if (!rst_an) begin
      if (wcredit || hit_valid || hit) begin
        $display("ERROR %0t: outputs not low during reset", $time);
        err_cnt++;
      end
    end else begin
      if (wcredit) begin
        pulse_cnt++;
      end
      if (hit_valid !== pend_valid) begin
        $display("search result %s at %0t",
                 hit_valid ? "without a search" : "missing", $time);
        err_cnt++;
      end else if (!pend_valid && hit !== 1'b0) begin
        $display("ERROR %0t: hit high with no search result", $time);
        err_cnt++;
      end else if (pend_valid && hit !== pend_hit) begin
        $display("ERROR %0t: key %h expected hit %0b, got %0b",
                 $time, pend_key, pend_hit, hit);
        err_cnt++;
      end else if (pend_hit && hit_data !== pend_data) begin
        $display("ERROR %0t: key %h expected data %h, got %h",
                 $time, pend_key, pend_data, hit_data);
        err_cnt++;
      end
      if (wcredit !== credit_due) begin
        $display("credit pulse %s at %0t",
                 wcredit ? "without a hit" : "missing after a hit", $time);
        err_cnt++;
      end
    end
  end

endmodule

// File: tests/cam_tb.sv
`timescale 1ns/1ps
`include "cam_defines.svh"

module cam_tb
  import cam_pkg::*;
();

  localparam int RAND_CYCLES = 300;
  // rough length of each test in cycles, reset first.
  localparam int TEST_CYCLES = 16 + 10 + 12 + 140 + 65 + 20 + RAND_CYCLES + 10;
  localparam int CYCLE_LIMIT = TEST_CYCLES + 100;

  logic        clk;
  logic        rst_an;
  logic        write_valid;
  cam_data_t   write_data;
  logic        wcredit;
  logic        search_valid;
  cam_key_t    search_key;
  logic        hit_valid;
  logic        hit;
  cam_data_t   hit_data;
  logic        exp_hit;
  cam_data_t   exp_data;
  int          errors;
  int          pulses;

  // reference state.
  cam_data_t   m_data [`CAM_DEPTH];
  bit          m_valid [`CAM_DEPTH];
  int          m_fresh = 0;
  cam_loc_t    m_free_q [$];
  int          m_hits = 0;

  int          spent = 0;
  int          returned = 0;
  int          cycles = 0;
  int          tb_errors = 0;
  int          last_total = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  logic [15:0] lfsr = 16'd74;

  cam_top cam_top_inst (.*);
  cam_checker cam_checker_inst (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // the sender sees a returned credit from the next edge on.
  always @(posedge clk) begin
    if (wcredit) begin
      returned <= returned + 1;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("run stopped after %0d cycles without finishing", cycles);
      $display("Test failures found");
      $finish;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // helpers and reference model.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // galois lfsr, one step per bit.
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
    end
    return v;
  endfunction

  function automatic int credits_left();
    return `CAM_DEPTH - spent + returned;
  endfunction

  // lowest valid location whose low bits equal the key.
  function automatic logic ref_search(input cam_key_t key, output cam_data_t data,
                                      output int loc);
    logic found;
    found = 1'b0;
    data  = '0;
    loc   = 0;
    for (int i = 0; i < `CAM_DEPTH; i++) begin
      if (!found && m_valid[i] && m_data[i][`CAM_KEY_W-1:0] == key) begin
        found = 1'b1;
        data  = m_data[i];
        loc   = i;
      end
    end
    return found;
  endfunction

  // one clock of stimulus; the search sees the state before the write.
  task automatic do_cycle(input logic wr, input cam_data_t wdata, input logic sr,
                          input cam_key_t key);
    cam_data_t d;
    int        loc;
    logic      h;
    h = 1'b0;
    d = '0;
    if (sr) begin
      h = ref_search(key, d, loc);
      if (h) begin
        m_valid[loc] = 1'b0;
        m_free_q.push_back(cam_loc_t'(loc));
        m_hits++;
      end
    end
    if (wr) begin
      if (m_fresh < `CAM_DEPTH) begin
        loc = m_fresh;
        m_fresh++;
      end else begin
        loc = int'(m_free_q.pop_front());
      end
      m_data[loc]  = wdata;
      m_valid[loc] = 1'b1;
      spent++;
    end
    write_valid  = wr;
    write_data   = wdata;
    search_valid = sr;
    search_key   = key;
    exp_hit      = h;
    exp_data     = d;
    @(negedge clk);
    write_valid  = 1'b0;
    search_valid = 1'b0;
  endtask

  task automatic write_entry(input cam_data_t wdata);
    while (credits_left() == 0) begin
      @(negedge clk);
    end
    do_cycle(1'b1, wdata, 1'b0, '0);
  endtask

  task automatic search_entry(input cam_key_t key);
    do_cycle(1'b0, '0, 1'b1, key);
  endtask

  task automatic end_test(input string name);
    int total;
    repeat (4) @(negedge clk);
    @(posedge clk);
    if (pulses != m_hits) begin
      $display("wrong number of credit pulses after %s: %0d seen, %0d hits",
               name, pulses, m_hits);
      tb_errors++;
    end
    total = errors + tb_errors;
    tests_run++;
    if (total != last_total) begin
      tests_failed++;
    end
    $display("test %0d %s: %s", tests_run, name, (total == last_total) ? "ok" : "failed");
    last_total = total;
    @(negedge clk);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // tests.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    int        n;
    logic      wr;
    logic      sr;
    cam_data_t d;
    cam_key_t  k;
    rst_an       = 1'b0;
    write_valid  = 1'b0;
    write_data   = '0;
    search_valid = 1'b0;
    search_key   = '0;
    exp_hit      = 1'b0;
    exp_data     = '0;
    repeat (16) @(negedge clk);
    rst_an = 1'b1;

    search_entry(15'h0000);
    search_entry(cam_key_t'(rand_bits(15)));
    end_test("reset and empty search");

    // a search at the same edge as the write must miss.
    do_cycle(1'b1, 20'hB1234, 1'b1, 15'h1234);
    search_entry(15'h1234);
    search_entry(15'h1234);
    end_test("write then search");

    n = 0;
    while (credits_left() > 0) begin
      write_entry({5'(n), 15'h2000 + 15'(n)});
      n++;
    end
    search_entry(15'h2000 + 15'd99);
    for (int j = 0; j < 20; j++) begin
      search_entry(15'h2000 + 15'((j * 37) % 100));
    end
    for (int j = 0; j < 5; j++) begin
      search_entry(15'h2000 + 15'((j * 37) % 100));
    end
    end_test("fill and credit return");

    // shared keys make the reuse order visible through priority.
    n = credits_left();
    for (int i = 0; i < n; i++) begin
      write_entry({5'(i), 15'h3000 + 15'(i % 4)});
    end
    for (int j = 0; j < 28; j++) begin
      search_entry(15'h3000 + 15'(j % 4));
    end
    for (int j = 0; j < 5; j++) begin
      search_entry(15'h2000 + 15'((j * 37) % 100));
    end
    end_test("free list reuse order");

    for (int i = 1; i <= 4; i++) begin
      write_entry({5'(i), 15'h4444});
    end
    repeat (5) search_entry(15'h4444);
    end_test("shared key priority");

    repeat (RAND_CYCLES) begin
      wr = rand_bits(1) != 0;
      sr = rand_bits(1) != 0;
      d  = {5'(rand_bits(5)), 12'h7FF, 3'(rand_bits(3))};
      k  = {12'h7FF, 3'(rand_bits(3))};
      do_cycle(wr && credits_left() > 0, d, sr, k);
    end
    end_test("random mix");

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, last_total);
    if (last_total == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
